//--- Bender.yml
package:
  name: tinycpu

sources:
  - hdl/tinycpu_pkg.sv
  - hdl/tinycpu_core.sv
  - hdl/bus_arbiter.sv
  - hdl/prog_mem.sv
  - hdl/out_collector.sv
  - hdl/tinycpu_top.sv
  - target: simulation
    files:
      - tb/tb_tinycpu.sv

//--- hdl/bus_arbiter.sv
// Round-robin Wishbone classic arbiter; the grant is held from the first stb until the ack
module bus_arbiter #(
    parameter int NUM_CORES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  tinycpu_pkg::wb_req_t core_req [NUM_CORES],
    output tinycpu_pkg::wb_rsp_t core_rsp [NUM_CORES],
    output tinycpu_pkg::wb_req_t mem_req,
    input  tinycpu_pkg::wb_rsp_t mem_rsp
);

    localparam int PW = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    logic [PW-1:0]        grant_q;   // Last or current holder
    logic [PW-1:0]        pick;
    logic [PW-1:0]        sel;
    logic                 found;
    logic                 locked_q;
    logic [NUM_CORES-1:0] ack_vec;

    // Search starts just past the last holder
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = grant_q;
        for (int i = 1; i <= NUM_CORES; i++) begin
            idx = (int'(grant_q) + i) % NUM_CORES;
            if (!found && core_req[idx].cyc) begin
                found = 1'b1;
                pick  = PW'(idx);
            end
        end
    end

    assign sel     = locked_q ? grant_q : pick;
    assign mem_req = (locked_q || found) ? core_req[sel] : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_q  <= PW'(NUM_CORES - 1);  // Core 0 wins first
            locked_q <= 1'b0;
        end else if (locked_q) begin
            if (mem_rsp.ack)
                locked_q <= 1'b0;
        end else if (found) begin
            grant_q  <= pick;
            locked_q <= 1'b1;
        end
    end

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_rsp
        assign ack_vec[i]  = locked_q && mem_rsp.ack && (grant_q == PW'(i));
        assign core_rsp[i] = '{ack: ack_vec[i], dat_r: mem_rsp.dat_r};
    end

    // Memory only acks the open cycle of the grant holder, and then exactly one core sees it
    a_one_ack: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.ack |-> locked_q && core_req[grant_q].stb && $onehot(ack_vec));

endmodule

//--- hdl/out_collector.sv
// One slot per core merged round-robin; out_core is 2 bits so up to four cores are labelled
module out_collector #(
    parameter int NUM_CORES = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  tinycpu_pkg::out_item_t core_out [NUM_CORES],
    output logic [NUM_CORES-1:0]   slot_full,
    output logic                   out_valid,
    output logic [7:0]             out_data,
    output logic [1:0]             out_core,
    input  logic                   out_ready
);

    localparam int PW = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    logic [NUM_CORES-1:0] slot_valid;
    logic [7:0]           slot_data [NUM_CORES];
    logic [PW-1:0]        sel_q;
    logic [PW-1:0]        next_sel;
    logic                 next_found;
    logic                 xfer;

    assign out_valid = slot_valid[sel_q];
    assign out_data  = slot_data[sel_q];
    assign out_core  = 2'(sel_q);
    assign xfer      = out_valid && out_ready;
    assign slot_full = slot_valid;

    // Next filled slot after the current choice
    always_comb begin
        int idx;
        next_found = 1'b0;
        next_sel   = sel_q;
        for (int i = 1; i < NUM_CORES; i++) begin
            idx = (int'(sel_q) + i) % NUM_CORES;
            if (!next_found && slot_valid[idx]) begin
                next_found = 1'b1;
                next_sel   = PW'(idx);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_valid <= '0;
            sel_q      <= '0;
        end else begin
            if ((xfer || !out_valid) && next_found)
                sel_q <= next_sel;  // Choice only moves when idle or after a transfer
            for (int i = 0; i < NUM_CORES; i++) begin
                if (xfer && sel_q == PW'(i))
                    slot_valid[i] <= 1'b0;
                if (core_out[i].valid)
                    slot_valid[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CORES; i++) begin
            if (core_out[i].valid)
                slot_data[i] <= core_out[i].data;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_core));

endmodule

//--- hdl/prog_mem.sv
// Program memory; MEM_WORDS must be a power of two, addresses wrap, bus side is read-only
module prog_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  tinycpu_pkg::wb_req_t bus_req,
    output tinycpu_pkg::wb_rsp_t bus_rsp,
    input  logic                 load_en,
    input  tinycpu_pkg::addr_t   load_addr,
    input  tinycpu_pkg::word_t   load_data
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    tinycpu_pkg::word_t mem [MEM_WORDS];
    tinycpu_pkg::word_t rd_data;
    logic               ack_q;
    logic               rd_req;

    // No second ack while stb is still held in the ack cycle
    assign rd_req = bus_req.cyc && bus_req.stb && !ack_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ack_q <= 1'b0;
        else
            ack_q <= rd_req;
    end

    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr[AW-1:0]] <= load_data;  // Loader only
        if (rd_req)
            rd_data <= mem[bus_req.adr[AW-1:0]];
    end

    assign bus_rsp = '{ack: ack_q, dat_r: rd_data};

endmodule

//--- hdl/tinycpu_core.sv
// Core stays idle until run rises once; OUTLOC reads START_ADDR plus operand, bad opcodes fault
module tinycpu_core #(
    parameter tinycpu_pkg::addr_t START_ADDR = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    output tinycpu_pkg::wb_req_t   wb_req,
    input  tinycpu_pkg::wb_rsp_t   wb_rsp,
    output tinycpu_pkg::out_item_t out_item,
    input  logic                   slot_full,
    output logic                   halted,
    output logic                   fault
);

    tinycpu_pkg::core_state_e state;
    tinycpu_pkg::core_state_e state_d;
    tinycpu_pkg::addr_t       pc;
    tinycpu_pkg::addr_t       bus_adr;
    tinycpu_pkg::instr_t      instr;

    logic       running;
    logic       bus_active;
    logic [7:0] regs [16];
    logic [7:0] emit_data;
    logic [7:0] exec_byte;
    logic [7:0] byte_d;
    logic       out_valid_q;

    logic pc_inc;
    logic emit_now;
    logic instr_we;
    logic byte_we;
    logic reg_we;
    logic fault_set;

    assign exec_byte = (instr.op == tinycpu_pkg::OUTR) ? regs[instr.rsel] : instr.operand;

    always_comb begin
        state_d   = state;
        pc_inc    = 1'b0;
        emit_now  = 1'b0;
        instr_we  = 1'b0;
        byte_we   = 1'b0;
        byte_d    = exec_byte;
        reg_we    = 1'b0;
        fault_set = 1'b0;
        case (state)
            tinycpu_pkg::FETCH: begin
                if (wb_rsp.ack) begin
                    instr_we = 1'b1;
                    state_d  = tinycpu_pkg::EXEC;
                end
            end
            tinycpu_pkg::EXEC: begin
                case (instr.op)
                    tinycpu_pkg::OUT, tinycpu_pkg::OUTR: begin
                        byte_we = 1'b1;
                        if (slot_full) begin
                            state_d = tinycpu_pkg::EMIT;  // Park the byte
                        end else begin
                            emit_now = 1'b1;
                            pc_inc   = 1'b1;
                            state_d  = tinycpu_pkg::FETCH;
                        end
                    end
                    tinycpu_pkg::LI: begin
                        reg_we  = 1'b1;
                        pc_inc  = 1'b1;
                        state_d = tinycpu_pkg::FETCH;
                    end
                    tinycpu_pkg::OUTLOC: state_d = tinycpu_pkg::LOAD;
                    tinycpu_pkg::HALT:   state_d = tinycpu_pkg::HALTED;
                    default: begin
                        fault_set = 1'b1;
                        state_d   = tinycpu_pkg::HALTED;
                    end
                endcase
            end
            tinycpu_pkg::LOAD: begin
                if (wb_rsp.ack) begin
                    byte_we = 1'b1;
                    byte_d  = wb_rsp.dat_r[7:0];
                    state_d = tinycpu_pkg::EMIT;
                end
            end
            tinycpu_pkg::EMIT: begin
                if (!slot_full) begin
                    emit_now = 1'b1;
                    pc_inc   = 1'b1;
                    state_d  = tinycpu_pkg::FETCH;
                end
            end
            default: state_d = state;  // HALTED is terminal
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= tinycpu_pkg::FETCH;
            running     <= 1'b0;
            pc          <= START_ADDR;
            out_valid_q <= 1'b0;
            fault       <= 1'b0;
        end else begin
            if (run)
                running <= 1'b1;
            state       <= state_d;
            out_valid_q <= emit_now;
            if (pc_inc)
                pc <= pc + 16'd1;
            if (fault_set)
                fault <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_we)
            instr <= tinycpu_pkg::instr_t'(wb_rsp.dat_r);
        if (byte_we)
            emit_data <= byte_d;
        if (reg_we)
            regs[instr.rsel] <= instr.operand;
    end

    // OUTLOC data sits in this core's region
    assign bus_adr    = (state == tinycpu_pkg::LOAD) ? START_ADDR + {8'h00, instr.operand} : pc;
    assign bus_active = running && (state == tinycpu_pkg::FETCH || state == tinycpu_pkg::LOAD);

    assign wb_req = '{cyc: bus_active, stb: bus_active, adr: bus_adr, we: 1'b0, dat_w: '0};
    assign out_item = '{valid: out_valid_q, data: emit_data};
    assign halted   = (state == tinycpu_pkg::HALTED);

    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr));

    // The slot is freed only by the collector, so a registered emit must still find it empty
    a_emit_free: assert property (@(posedge clk) disable iff (rst)
        out_item.valid |-> !slot_full);

endmodule

//--- hdl/tinycpu_pkg.sv
// Shared types for the cluster; addresses count 16-bit words and the core bus never writes
package tinycpu_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [15:0] word_t;

    typedef enum logic [3:0] {
        OUT    = 4'd1,  // Emit operand
        OUTLOC = 4'd2,  // Emit low byte of region word
        LI     = 4'd3,  // Load register
        OUTR   = 4'd4,  // Emit register
        HALT   = 4'd5
    } opcode_e;

    // Instruction word layout, MSB first
    typedef struct packed {
        logic [3:0] rsel;
        opcode_e    op;
        logic [7:0] operand;
    } instr_t;

    // Wishbone classic master side
    typedef struct packed {
        logic  cyc;
        logic  stb;
        addr_t adr;
        logic  we;     // Tied low by the cores
        word_t dat_w;  // Unused, no bus writes
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } out_item_t;

    typedef enum logic [2:0] {
        FETCH,
        EXEC,
        LOAD,   // Data read for OUTLOC
        EMIT,   // Waiting on a free output slot
        HALTED
    } core_state_e;

endpackage

//--- hdl/tinycpu_top.sv
// Cluster top; load the memory while run is low, core c starts at c * REGION_WORDS
module tinycpu_top #(
    parameter int NUM_CORES    = 4,
    parameter int MEM_WORDS    = 256,
    parameter int REGION_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    input  logic                 load_en,
    input  tinycpu_pkg::addr_t   load_addr,
    input  tinycpu_pkg::word_t   load_data,
    output logic                 out_valid,
    output logic [7:0]           out_data,
    output logic [1:0]           out_core,
    input  logic                 out_ready,
    output logic [NUM_CORES-1:0] halted,
    output logic [NUM_CORES-1:0] fault,
    output logic                 all_halted
);

    tinycpu_pkg::wb_req_t   core_req [NUM_CORES];
    tinycpu_pkg::wb_rsp_t   core_rsp [NUM_CORES];
    tinycpu_pkg::wb_req_t   mem_req;
    tinycpu_pkg::wb_rsp_t   mem_rsp;
    tinycpu_pkg::out_item_t core_out [NUM_CORES];
    logic [NUM_CORES-1:0]   slot_full;

    prog_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) u_mem (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (mem_req),
        .bus_rsp  (mem_rsp),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data)
    );

    bus_arbiter #(
        .NUM_CORES(NUM_CORES)
    ) u_arb (
        .clk     (clk),
        .rst     (rst),
        .core_req(core_req),
        .core_rsp(core_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        tinycpu_core #(
            .START_ADDR(tinycpu_pkg::addr_t'(c * REGION_WORDS))
        ) u_core (
            .clk      (clk),
            .rst      (rst),
            .run      (run),
            .wb_req   (core_req[c]),
            .wb_rsp   (core_rsp[c]),
            .out_item (core_out[c]),
            .slot_full(slot_full[c]),
            .halted   (halted[c]),
            .fault    (fault[c])
        );
    end

    out_collector #(
        .NUM_CORES(NUM_CORES)
    ) u_out (
        .clk      (clk),
        .rst      (rst),
        .core_out (core_out),
        .slot_full(slot_full),
        .out_valid(out_valid),
        .out_data (out_data),
        .out_core (out_core),
        .out_ready(out_ready)
    );

    assign all_halted = &halted;

endmodule

//--- tb/tb_tinycpu.sv
// Runs from the project root; vectors come from tb/tinycpu_vectors.txt and core 3 must fault
module tb_tinycpu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CORES    = 4;
    localparam int MEM_WORDS    = 256;
    localparam int REGION_WORDS = 64;
    localparam int CLK_PERIOD   = 4;

    logic                 clk;
    logic                 rst;
    logic                 run;
    logic                 load_en;
    tinycpu_pkg::addr_t   load_addr;
    tinycpu_pkg::word_t   load_data;
    logic                 out_valid;
    logic [7:0]           out_data;
    logic [1:0]           out_core;
    logic                 out_ready;
    logic [NUM_CORES-1:0] halted;
    logic [NUM_CORES-1:0] fault;
    logic                 all_halted;

    tinycpu_pkg::addr_t load_addr_q [$];
    tinycpu_pkg::word_t load_word_q [$];
    logic [7:0]         exp_q [NUM_CORES][$];  // Expected bytes per core
    int                 num_exp;
    int                 mismatches;
    int                 other_errors;
    bit                 vectors_ready;

    tinycpu_top #(
        .NUM_CORES   (NUM_CORES),
        .MEM_WORDS   (MEM_WORDS),
        .REGION_WORDS(REGION_WORDS)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_core  (out_core),
        .out_ready (out_ready),
        .halted    (halted),
        .fault     (fault),
        .all_halted(all_halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic read_vectors(output bit ok);
        int          fd;
        int          n;
        int          core;
        string       line;
        logic [15:0] a;
        logic [15:0] w;
        logic [7:0]  b;
        ok = 1'b0;
        fd = $fopen("tb/tinycpu_vectors.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0)
                break;
            if ($sscanf(line, "L %h %h", a, w) == 2) begin
                load_addr_q.push_back(a);
                load_word_q.push_back(w);
            end else if ($sscanf(line, "E %d %h", core, b) == 2) begin
                assert (core >= 0 && core < NUM_CORES) else begin
                    other_errors++;
                    $display("Vector file names core %0d, which does not exist", core);
                end
                if (core >= 0 && core < NUM_CORES) begin
                    exp_q[core].push_back(b);
                    num_exp++;
                end
            end
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < load_addr_q.size(); i++) begin
            load_en   = 1'b1;
            load_addr = load_addr_q[i];
            load_data = load_word_q[i];
            @(posedge clk);
            #0.5;
        end
        load_en = 1'b0;
    endtask

    // Runs the cores with random back-pressure until every slot has drained
    task automatic run_and_drain();
        int idle;
        idle = 0;
        run  = 1'b1;
        while (idle < 8) begin
            @(posedge clk);
            #0.5;
            out_ready = ($urandom_range(99) < 60);
            if (all_halted && !out_valid)
                idle++;
            else
                idle = 0;
        end
    endtask

    task automatic check_final_state();
        for (int c = 0; c < NUM_CORES; c++) begin
            assert (exp_q[c].size() == 0) else begin
                other_errors++;
                $display("Core %0d ended with %0d expected bytes never sent", c, exp_q[c].size());
            end
        end
        assert (halted == 4'b1111) else begin
            mismatches++;
            $display("Mismatch at %0d ns: halted expected 1111 got %b", $time, halted);
        end
        assert (fault == 4'b1000) else begin
            mismatches++;
            $display("Mismatch at %0d ns: fault expected 1000 got %b", $time, fault);
        end
    endtask

    // Transfer happens at the next rising edge
    always @(negedge clk) begin
        logic [7:0] exp_byte;
        if (!rst && out_valid && out_ready) begin
            assert (exp_q[out_core].size() > 0) else begin
                other_errors++;
                $display("Core %0d sent byte 0x%02h with nothing left to expect", out_core,
                         out_data);
            end
            if (exp_q[out_core].size() > 0) begin
                exp_byte = exp_q[out_core].pop_front();
                assert (out_data == exp_byte) else begin
                    mismatches++;
                    $display("Mismatch at %0d ns: out_data core %0d expected 0x%02h got 0x%02h",
                             $time, out_core, exp_byte, out_data);
                end
            end
        end
    end

    initial begin
        int watch_cycles;
        wait (vectors_ready);
        watch_cycles = load_addr_q.size() + 40 * num_exp + 200;
        #(watch_cycles * CLK_PERIOD);
        $display("Timeout after %0d cycles: not all cores halted and drained", watch_cycles);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors + 1);
        $display("Regression failed");
        $finish;
    end

    initial begin
        bit ok;
        void'($urandom(60341));
        clk       = 1'b0;
        rst       = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        out_ready = 1'b0;
        read_vectors(ok);
        if (!ok) begin
            $display("Cannot open the vector file tb/tinycpu_vectors.txt");
            $display("Regression failed");
            $finish;
        end else begin
            vectors_ready = 1'b1;
            repeat (8) @(posedge clk);
            #0.5;
            assert (!out_valid && halted == '0 && fault == '0 && !all_halted) else begin
                other_errors++;
                $display("Outputs not low during reset");
            end
            rst = 1'b0;
            load_program();  // Cores stay idle while run is low
            run_and_drain();
            check_final_state();
            $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
            if (mismatches == 0 && other_errors == 0)
                $display("Regression passed");
            else
                $display("Regression failed");
            $finish;
        end
    end

endmodule

//--- tb/tinycpu_vectors.txt
# L <word address hex> <instruction or data word hex>   load into program memory
# E <core decimal> <byte hex>   next byte expected from that core, in order
# Core 0, region 0x0000
L 0000 0111
L 0001 235A
L 0002 2400
L 0003 0122
L 0004 0500
E 0 11
E 0 5A
E 0 22
# Core 1, region 0x0040, OUTLOC reads 0x0060
L 0040 0220
L 0041 0133
L 0042 73C3
L 0043 7400
L 0044 0500
L 0060 BEEF
E 1 EF
E 1 33
E 1 C3
# Core 2, region 0x0080, OUTLOC reads 0x00B0
L 0080 0144
L 0081 0230
L 0082 F399
L 0083 F400
L 0084 0155
L 0085 0500
L 00B0 12A5
E 2 44
E 2 A5
E 2 99
E 2 55
# Core 3, region 0x00C0, opcode F faults before the last OUT
L 00C0 0166
L 00C1 1377
L 00C2 1400
L 00C3 0F00
L 00C4 0188
E 3 66
E 3 77

//--- verilog.f
hdl/tinycpu_pkg.sv
hdl/tinycpu_core.sv
hdl/bus_arbiter.sv
hdl/prog_mem.sv
hdl/out_collector.sv
hdl/tinycpu_top.sv
tb/tb_tinycpu.sv
